// ==== common/lcd_pkg.sv ====
// Shared types for the LCD SPI controller
// APB address is 5 bits wide and byte addressed, all registers are 32-bit
// Coordinates are 9 bits, which covers a 320x240 panel in either orientation
// Pixel format is RGB565 only

`default_nettype none

package lcd_pkg;

	// ==============================
	// APB
	// ==============================

	typedef struct packed {
		logic [4:0]  paddr;
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// ==============================
	// Link items and fill setup
	// ==============================

	typedef struct packed {
		logic       rs;    // 0 command, 1 data
		logic [7:0] data;
		logic       last;  // Final byte of a fill
	} lcd_item_t;

	typedef struct packed {
		logic [8:0]  x0;
		logic [8:0]  x1;
		logic [8:0]  y0;
		logic [8:0]  y1;
		logic [15:0] color;  // RGB565
	} fill_cfg_t;

	localparam logic [4:0] REG_CMD        = 5'h00;
	localparam logic [4:0] REG_DATA       = 5'h04;
	localparam logic [4:0] REG_CTRL       = 5'h08;
	localparam logic [4:0] REG_STATUS     = 5'h0C;
	localparam logic [4:0] REG_FILL_X     = 5'h10;
	localparam logic [4:0] REG_FILL_Y     = 5'h14;
	localparam logic [4:0] REG_FILL_COLOR = 5'h18;

	localparam logic [7:0] LCD_CASET = 8'h2A;  // Column address set
	localparam logic [7:0] LCD_PASET = 8'h2B;  // Page address set
	localparam logic [7:0] LCD_RAMWR = 8'h2C;  // Memory write

endpackage

`default_nettype wire

// ==== logic/lcd_spi_shifter.sv ====
// SPI mode 0 byte shifter, MSB first, one byte per start
// SCK half-period is CLK_DIV clocks, CLK_DIV must be at least 1
// Start to done takes exactly 16*CLK_DIV clocks
// A start while busy is ignored

`timescale 1ns/1ns
`default_nettype none

module lcd_spi_shifter #(
	parameter int CLK_DIV = 2
) (
	input  wire        i_clock,
	input  wire        i_rst_n,
	input  wire        i_start,
	input  wire  [7:0] i_tx,
	output logic       o_busy,
	output logic       o_done,
	output logic [7:0] o_rx,
	output logic       o_sck,
	output logic       o_mosi,
	input  wire        i_miso
);

	localparam int DW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam logic [DW-1:0] DIV_LAST = DW'(CLK_DIV - 1);

	logic [DW-1:0] div_cnt;
	logic [2:0]    bit_cnt;
	logic [7:0]    tx_sh;
	logic [7:0]    rx_sh;
	logic          load;
	logic          half_end;
	logic          sck_rise;
	logic          sck_fall;

	assign load     = !o_busy && i_start;
	assign half_end = o_busy && (div_cnt == DIV_LAST);
	assign sck_rise = half_end && !o_sck;
	assign sck_fall = half_end && o_sck;

	// ==============================
	// Control and pins
	// ==============================

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_busy  <= 1'b0;
			o_done  <= 1'b0;
			o_rx    <= '0;
			o_sck   <= 1'b0;
			o_mosi  <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			o_done <= 1'b0;
			if (load) begin
				o_busy  <= 1'b1;
				o_mosi  <= i_tx[7];  // First bit set up at once
				div_cnt <= '0;
				bit_cnt <= '0;
			end else if (half_end) begin
				div_cnt <= '0;
				o_sck   <= !o_sck;
				if (sck_fall) begin
					if (bit_cnt == 3'd7) begin
						o_busy <= 1'b0;
						o_done <= 1'b1;
						o_rx   <= rx_sh;
						o_mosi <= 1'b0;  // Park low
					end else begin
						o_mosi  <= tx_sh[7];
						bit_cnt <= bit_cnt + 3'd1;
					end
				end
			end else if (o_busy) begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// Shift registers
	always_ff @(posedge i_clock) begin
		if (load) begin
			tx_sh <= {i_tx[6:0], 1'b0};
		end else if (sck_fall) begin
			tx_sh <= {tx_sh[6:0], 1'b0};
		end
		if (sck_rise) begin
			rx_sh <= {rx_sh[6:0], i_miso};  // Sample on SCK rising
		end
	end

endmodule

`default_nettype wire

// ==== logic/lcd_fill_engine.sv ====
// Rectangle fill byte generator
// Emits CASET, PASET, RAMWR and then the pixels as a valid/ready stream
// Coordinates may be given in either order, the pixel count uses |x1-x0|+1
// A start while a fill is running is ignored

`timescale 1ns/1ns
`default_nettype none

module lcd_fill_engine import lcd_pkg::*; (
	input  wire            i_clock,
	input  wire            i_rst_n,
	input  wire            i_start,
	input  wire fill_cfg_t i_cfg,
	output lcd_item_t      o_item,
	output logic           o_item_valid,
	input  wire            i_item_ready
);

	typedef enum logic [1:0] {ST_IDLE, ST_HDR, ST_PIX} state_t;

	state_t      state;
	fill_cfg_t   cfg_q;
	logic [3:0]  hdr_idx;
	logic        hi_sel;     // High color byte is next
	logic [19:0] pix_left;
	logic [8:0]  dx;
	logic [8:0]  dy;
	logic [9:0]  width;
	logic [9:0]  height;
	logic [19:0] pix_total;
	logic        take;

	// Header bytes, 11 in all
	function automatic lcd_item_t hdr_item(input logic [3:0] idx, input fill_cfg_t cfg);
		lcd_item_t it;
		it.rs   = 1'b1;
		it.last = 1'b0;
		case (idx)
			4'd0:    it.data = LCD_CASET;
			4'd1:    it.data = {7'b0, cfg.x0[8]};
			4'd2:    it.data = cfg.x0[7:0];
			4'd3:    it.data = {7'b0, cfg.x1[8]};
			4'd4:    it.data = cfg.x1[7:0];
			4'd5:    it.data = LCD_PASET;
			4'd6:    it.data = {7'b0, cfg.y0[8]};
			4'd7:    it.data = cfg.y0[7:0];
			4'd8:    it.data = {7'b0, cfg.y1[8]};
			4'd9:    it.data = cfg.y1[7:0];
			default: it.data = LCD_RAMWR;
		endcase
		if (idx == 4'd0 || idx == 4'd5 || idx == 4'd10) begin
			it.rs = 1'b0;  // Command bytes
		end
		return it;
	endfunction

	assign dx        = (i_cfg.x1 >= i_cfg.x0) ? i_cfg.x1 - i_cfg.x0 : i_cfg.x0 - i_cfg.x1;
	assign dy        = (i_cfg.y1 >= i_cfg.y0) ? i_cfg.y1 - i_cfg.y0 : i_cfg.y0 - i_cfg.y1;
	assign width     = {1'b0, dx} + 10'd1;
	assign height    = {1'b0, dy} + 10'd1;
	assign pix_total = 20'(width) * 20'(height);
	assign take      = o_item_valid && i_item_ready;

	always_comb begin
		if (state == ST_PIX) begin
			o_item.rs   = 1'b1;
			o_item.data = hi_sel ? cfg_q.color[15:8] : cfg_q.color[7:0];
			o_item.last = !hi_sel && (pix_left == 20'd1);
		end else begin
			o_item = hdr_item(hdr_idx, cfg_q);
		end
	end

	assign o_item_valid = (state != ST_IDLE);

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state   <= ST_IDLE;
			hdr_idx <= '0;
			hi_sel  <= 1'b1;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_start) begin
						state   <= ST_HDR;
						hdr_idx <= '0;
					end
				end
				ST_HDR: begin
					if (take) begin
						if (hdr_idx == 4'd10) begin
							state  <= ST_PIX;
							hi_sel <= 1'b1;
						end else begin
							hdr_idx <= hdr_idx + 4'd1;
						end
					end
				end
				ST_PIX: begin
					if (take) begin
						hi_sel <= !hi_sel;
						if (!hi_sel && pix_left == 20'd1) begin
							state <= ST_IDLE;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Fill setup and pixel counter
	always_ff @(posedge i_clock) begin
		if (state == ST_IDLE && i_start) begin
			cfg_q    <= i_cfg;
			pix_left <= pix_total;
		end else if (state == ST_PIX && take && !hi_sel) begin
			pix_left <= pix_left - 20'd1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/lcd_ctrl.sv ====
// APB register block and byte sequencer for the LCD link
// CMD/DATA accesses stall the APB until the byte has been shifted
// During a fill, CMD/DATA/FILL_COLOR writes get pslverr and CMD/DATA reads
// wait until the fill is over; other registers stay accessible
// Chip select is held low for the whole fill

`timescale 1ns/1ns
`default_nettype none

module lcd_ctrl import lcd_pkg::*; (
	input  wire            i_clock,
	input  wire            i_rst_n,
	input  wire apb_req_t  i_apb,
	output apb_rsp_t       o_apb,
	output logic           o_start,
	output logic [7:0]     o_tx,
	input  wire            i_busy,
	input  wire            i_done,
	input  wire [7:0]      i_rx,
	output logic           o_fill_start,
	output fill_cfg_t      o_fill_cfg,
	input  wire lcd_item_t i_item,
	input  wire            i_item_valid,
	output logic           o_item_ready,
	output logic           o_lcd_rst_n,
	output logic           o_lcd_cs_n,
	output logic           o_lcd_rs
);

	typedef enum logic [2:0] {ST_IDLE, ST_XFER, ST_WAIT, ST_RESP, ST_FILL} state_t;

	state_t      state;
	logic [1:0]  ctrl_q;       // {lcd reset, manual cs_n}
	fill_cfg_t   cfg_q;
	logic        rs_q;
	logic [7:0]  tx_q;
	logic        last_q;       // Item in flight ends the fill
	logic        fill_active;
	logic        err_q;
	logic [31:0] prdata_q;
	logic        apb_acc;
	logic        is_link;
	logic        wr_err;
	logic        apb_take;
	logic        fill_go;
	logic [31:0] rd_mux;

	// ==============================
	// Decode
	// ==============================

	assign apb_acc  = i_apb.psel && i_apb.penable;
	assign is_link  = (i_apb.paddr == REG_CMD) || (i_apb.paddr == REG_DATA);
	assign wr_err   = i_apb.pwrite && fill_active &&
			(is_link || i_apb.paddr == REG_FILL_COLOR);
	assign apb_take = (state == ST_IDLE) && apb_acc &&
			!(fill_active && is_link && !i_apb.pwrite);  // Link reads wait for fill end

	assign o_item_ready = (state == ST_IDLE) && fill_active && !i_busy && !apb_take;
	assign fill_go      = o_item_ready && i_item_valid;

	always_comb begin
		case (i_apb.paddr)
			REG_CTRL:       rd_mux = {30'b0, ctrl_q};
			REG_STATUS:     rd_mux = {30'b0, fill_active, i_busy};
			REG_FILL_X:     rd_mux = {7'b0, cfg_q.x1, 7'b0, cfg_q.x0};
			REG_FILL_Y:     rd_mux = {7'b0, cfg_q.y1, 7'b0, cfg_q.y0};
			REG_FILL_COLOR: rd_mux = {16'b0, cfg_q.color};
			default:        rd_mux = '0;
		endcase
	end

	// Shifter gets either the direct byte or a fill item
	assign o_start = ((state == ST_XFER) && !i_busy) || fill_go;
	assign o_tx    = fill_go ? i_item.data : tx_q;

	assign o_apb.prdata  = prdata_q;
	assign o_apb.pready  = (state == ST_RESP);
	assign o_apb.pslverr = (state == ST_RESP) && err_q;

	assign o_fill_cfg  = cfg_q;
	assign o_lcd_rst_n = ctrl_q[1];
	assign o_lcd_cs_n  = fill_active ? 1'b0 : ctrl_q[0];
	assign o_lcd_rs    = rs_q;

	// ==============================
	// Sequencer
	// ==============================

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state        <= ST_IDLE;
			ctrl_q       <= 2'b01;  // Deselected, LCD held in reset
			cfg_q        <= '0;
			rs_q         <= 1'b0;
			last_q       <= 1'b0;
			fill_active  <= 1'b0;
			o_fill_start <= 1'b0;
			err_q        <= 1'b0;
			prdata_q     <= '0;
		end else begin
			o_fill_start <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (apb_take) begin
						err_q    <= wr_err;
						prdata_q <= rd_mux;
						state    <= ST_RESP;
						if (!wr_err && is_link) begin
							tx_q  <= i_apb.pwrite ? i_apb.pwdata[7:0] : 8'h00;
							state <= ST_XFER;
							if (i_apb.pwrite) begin
								rs_q <= (i_apb.paddr == REG_DATA);
							end
						end else if (!wr_err && i_apb.pwrite) begin
							case (i_apb.paddr)
								REG_CTRL: ctrl_q <= i_apb.pwdata[1:0];
								REG_FILL_X: begin
									cfg_q.x0 <= i_apb.pwdata[8:0];
									cfg_q.x1 <= i_apb.pwdata[24:16];
								end
								REG_FILL_Y: begin
									cfg_q.y0 <= i_apb.pwdata[8:0];
									cfg_q.y1 <= i_apb.pwdata[24:16];
								end
								REG_FILL_COLOR: begin
									cfg_q.color  <= i_apb.pwdata[15:0];
									o_fill_start <= 1'b1;
									fill_active  <= 1'b1;
								end
								default: ;
							endcase
						end
					end else if (fill_go) begin
						rs_q   <= i_item.rs;
						last_q <= i_item.last;
						state  <= ST_FILL;
					end
				end
				ST_XFER: if (!i_busy) state <= ST_WAIT;
				ST_WAIT: begin
					if (i_done) begin
						prdata_q <= {24'b0, i_rx};  // Received byte
						state    <= ST_RESP;
					end
				end
				ST_RESP: state <= ST_IDLE;  // pready for one cycle
				ST_FILL: begin
					if (i_done) begin
						if (last_q) fill_active <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/lcd_spi_top.sv ====
// LCD controller top level, APB in and 4-wire SPI plus reset out
// CLK_DIV sets the SCK half-period in i_clock cycles, at least 1
// Pin levels after reset: cs_n high, SCK and MOSI low, LCD reset low

`timescale 1ns/1ns
`default_nettype none

module lcd_spi_top import lcd_pkg::*; #(
	parameter int CLK_DIV = 2
) (
	input  wire           i_clock,
	input  wire           i_rst_n,
	input  wire apb_req_t i_apb,
	output apb_rsp_t      o_apb,
	output logic          o_lcd_rst_n,
	output logic          o_lcd_cs_n,
	output logic          o_lcd_rs,
	output logic          o_lcd_mosi,
	input  wire           i_lcd_miso,
	output logic          o_lcd_sck
);

	// ==============================
	// Internal links
	// ==============================

	logic      spi_start;
	logic [7:0] spi_tx;
	logic      spi_busy;
	logic      spi_done;
	logic [7:0] spi_rx;
	logic      fill_start;
	fill_cfg_t fill_cfg;
	lcd_item_t item;
	logic      item_valid;
	logic      item_ready;

	lcd_ctrl u_ctrl (
		.i_clock      (i_clock),
		.i_rst_n      (i_rst_n),
		.i_apb        (i_apb),
		.o_apb        (o_apb),
		.o_start      (spi_start),
		.o_tx         (spi_tx),
		.i_busy       (spi_busy),
		.i_done       (spi_done),
		.i_rx         (spi_rx),
		.o_fill_start (fill_start),
		.o_fill_cfg   (fill_cfg),
		.i_item       (item),
		.i_item_valid (item_valid),
		.o_item_ready (item_ready),
		.o_lcd_rst_n  (o_lcd_rst_n),
		.o_lcd_cs_n   (o_lcd_cs_n),
		.o_lcd_rs     (o_lcd_rs)
	);

	lcd_spi_shifter #(
		.CLK_DIV (CLK_DIV)
	) u_shifter (
		.i_clock (i_clock),
		.i_rst_n (i_rst_n),
		.i_start (spi_start),
		.i_tx    (spi_tx),
		.o_busy  (spi_busy),
		.o_done  (spi_done),
		.o_rx    (spi_rx),
		.o_sck   (o_lcd_sck),
		.o_mosi  (o_lcd_mosi),
		.i_miso  (i_lcd_miso)
	);

	lcd_fill_engine u_fill (
		.i_clock      (i_clock),
		.i_rst_n      (i_rst_n),
		.i_start      (fill_start),
		.i_cfg        (fill_cfg),
		.o_item       (item),
		.o_item_valid (item_valid),
		.i_item_ready (item_ready)
	);

endmodule

`default_nettype wire

// ==== dv/lcd_spi_model.sv ====
// Behavioral LCD slave on a mode 0 SPI link
// Records every byte as {rs, data} while chip select is low
// Answers each byte with the inverse of the byte before it and 0xA5 at first
// Expects whole bytes only and never realigns on chip select

`timescale 1ns/1ns
`default_nettype none

module lcd_spi_model (
	input  wire         i_sck,
	input  wire         i_cs_n,
	input  wire         i_rs,
	input  wire         i_mosi,
	output logic        o_miso,
	output logic [31:0] o_count,
	output logic [8:0]  o_last
);

	logic [7:0] rx_sh;
	logic [2:0] rx_bits;
	logic [7:0] tx_byte;
	logic [7:0] tx_next;
	logic [2:0] tx_bit;

	initial begin
		rx_sh   = 8'h00;
		rx_bits = 3'd0;
		tx_byte = 8'hA5;
		tx_next = 8'hA5;
		tx_bit  = 3'd0;
		o_count = 32'd0;
		o_last  = 9'd0;
	end

	assign o_miso = tx_byte[3'd7 - tx_bit];  // MSB first

	// Capture on SCK rising
	always @(posedge i_sck) begin
		if (!i_cs_n) begin
			rx_sh = {rx_sh[6:0], i_mosi};
			if (rx_bits == 3'd7) begin
				o_last  = {i_rs, rx_sh};
				o_count = o_count + 32'd1;
				tx_next = ~rx_sh;  // Answer for the next byte
				rx_bits = 3'd0;
			end else begin
				rx_bits = rx_bits + 3'd1;
			end
		end
	end

	// Shift out on SCK falling
	always @(negedge i_sck) begin
		if (!i_cs_n) begin
			if (tx_bit == 3'd7) begin
				tx_bit  = 3'd0;
				tx_byte = tx_next;
			end else begin
				tx_bit = tx_bit + 3'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== dv/tb_lcd_spi.sv ====
// Testbench for the LCD SPI controller with the DUT built for CLK_DIV = 2
// Link bytes are checked against a behavioral LCD model
// Fill rectangles are at most 4x3 pixels to keep the run short
// Random stimulus comes from an LCG with a fixed seed

`timescale 1ns/1ns
`default_nettype none

module tb_lcd_spi import lcd_pkg::*;;

	localparam int CLK_DIV        = 2;
	localparam int N_DIRECT       = 20;
	localparam int N_READS        = 3;
	localparam int N_FILLS        = 5;  // Four plain fills and one under error writes
	localparam int MAX_FILL_BYTES = 11 + 2 * 4 * 3;
	localparam int MAX_BYTES      = N_DIRECT + N_READS + 1 + N_FILLS * MAX_FILL_BYTES;
	localparam int WATCHDOG_NS    = MAX_BYTES * 16 * CLK_DIV * 8 * 4 + 10000;

	logic        clock = 1'b0;
	logic        rst_n;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	logic        lcd_rst_n;
	logic        lcd_cs_n;
	logic        lcd_rs;
	logic        lcd_mosi;
	logic        lcd_miso;
	logic        lcd_sck;
	logic [31:0] model_count;
	logic [8:0]  model_last;

	logic [8:0]  exp_q[$];  // {rs, data} still expected on the link
	logic [31:0] lcg_state = 32'd74;
	logic [31:0] seen_count = 32'd0;
	logic [8:0]  want;
	int          err_cnt = 0;
	int          cmp_errs = 0;
	int          test_base = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	int          cs_falls = 0;
	int          cs_rises = 0;

	always #4 clock = ~clock;

	lcd_spi_top #(
		.CLK_DIV (CLK_DIV)
	) i_dut (
		.i_clock     (clock),
		.i_rst_n     (rst_n),
		.i_apb       (apb_req),
		.o_apb       (apb_rsp),
		.o_lcd_rst_n (lcd_rst_n),
		.o_lcd_cs_n  (lcd_cs_n),
		.o_lcd_rs    (lcd_rs),
		.o_lcd_mosi  (lcd_mosi),
		.i_lcd_miso  (lcd_miso),
		.o_lcd_sck   (lcd_sck)
	);

	lcd_spi_model u_model (
		.i_sck   (lcd_sck),
		.i_cs_n  (lcd_cs_n),
		.i_rs    (lcd_rs),
		.i_mosi  (lcd_mosi),
		.o_miso  (lcd_miso),
		.o_count (model_count),
		.o_last  (model_last)
	);

	// ==============================
	// Helpers
	// ==============================

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = lcg_next();
		return int'(r[30:16]) % n;
	endfunction

	function automatic void expect_data16(input logic [15:0] w);
		exp_q.push_back({1'b1, w[15:8]});  // High byte first
		exp_q.push_back({1'b1, w[7:0]});
	endfunction

	// Queues the expected link bytes of one fill and returns their count
	function automatic int expect_fill(input logic [8:0] x0, input logic [8:0] x1,
			input logic [8:0] y0, input logic [8:0] y1, input logic [15:0] color);
		int w;
		int h;
		w = int'(x1) - int'(x0);
		h = int'(y1) - int'(y0);
		if (w < 0) w = -w;
		if (h < 0) h = -h;
		exp_q.push_back({1'b0, LCD_CASET});
		expect_data16({7'b0, x0});
		expect_data16({7'b0, x1});
		exp_q.push_back({1'b0, LCD_PASET});
		expect_data16({7'b0, y0});
		expect_data16({7'b0, y1});
		exp_q.push_back({1'b0, LCD_RAMWR});
		for (int i = 0; i < (w + 1) * (h + 1); i++) begin
			expect_data16(color);
		end
		return 11 + 2 * (w + 1) * (h + 1);
	endfunction

	task automatic flag_error(input string msg);
		$display("ERROR %0t: %s", $time, msg);
		err_cnt = err_cnt + 1;
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = err_cnt + cmp_errs - test_base;
		if (errs == 0) begin
			tests_passed = tests_passed + 1;
			$display("Test %s: passed", name);
		end else begin
			tests_failed = tests_failed + 1;
			$display("Test %s: failed with %0d errors", name, errs);
		end
		test_base = err_cnt + cmp_errs;
	endtask

	// One APB transfer that waits for pready
	task automatic apb_access(input logic [4:0] addr, input logic wr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		@(posedge clock);
		apb_req.paddr   <= addr;
		apb_req.pwrite  <= wr;
		apb_req.pwdata  <= wdata;
		apb_req.psel    <= 1'b1;
		apb_req.penable <= 1'b0;
		@(posedge clock);
		apb_req.penable <= 1'b1;
		@(posedge clock);
		while (!apb_rsp.pready) @(posedge clock);
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		apb_req.psel    <= 1'b0;
		apb_req.penable <= 1'b0;
	endtask

	// Random coordinate pair in either order
	task automatic pick_span(input int max_len, input logic full, output logic [8:0] a,
			output logic [8:0] b);
		int len;
		len = full ? max_len : rand_below(max_len) + 1;
		a = 9'(rand_below(300) + 3);
		if (rand_below(2) == 1) b = a - 9'(len - 1);
		else b = a + 9'(len - 1);
	endtask

	task automatic start_fill(input logic [8:0] x0, input logic [8:0] x1, input logic [8:0] y0,
			input logic [8:0] y1, input logic [15:0] color, output int n);
		logic [31:0] rd;
		logic        err;
		apb_access(REG_FILL_X, 1'b1, {7'b0, x1, 7'b0, x0}, rd, err);
		apb_access(REG_FILL_Y, 1'b1, {7'b0, y1, 7'b0, y0}, rd, err);
		n = expect_fill(x0, x1, y0, y1, color);
		apb_access(REG_FILL_COLOR, 1'b1, {16'b0, color}, rd, err);
		if (err !== 1'b0) flag_error("FILL_COLOR write returned pslverr while idle");
	endtask

	// Polls STATUS until the fill bit drops
	task automatic wait_fill_done(output logic first_active);
		logic [31:0] st;
		logic        err;
		apb_access(REG_STATUS, 1'b0, 32'd0, st, err);
		first_active = st[1];
		while (st[1]) apb_access(REG_STATUS, 1'b0, 32'd0, st, err);
	endtask

	task automatic drain_bytes();
		repeat (4) @(posedge clock);
		if (exp_q.size() != 0) begin
			flag_error($sformatf("%0d expected link bytes never arrived", exp_q.size()));
			exp_q.delete();
		end
	endtask

	// ==============================
	// Checkers and watchdog
	// ==============================

	always @(negedge clock) begin
		if (model_count != seen_count) begin
			seen_count = seen_count + 32'd1;
			if (exp_q.size() == 0) begin
				$display("ERROR %0t: unexpected link byte rs=%0b data=%02h", $time,
					model_last[8], model_last[7:0]);
				cmp_errs = cmp_errs + 1;
			end else begin
				want = exp_q.pop_front();
				if (model_last !== want) begin
					$display("ERROR %0t: link byte rs=%0b data=%02h, expected rs=%0b data=%02h",
						$time, model_last[8], model_last[7:0], want[8], want[7:0]);
					cmp_errs = cmp_errs + 1;
				end
			end
		end
	end

	always @(negedge lcd_cs_n) cs_falls = cs_falls + 1;
	always @(posedge lcd_cs_n) cs_rises = cs_rises + 1;

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("CHECKS FAILED");
		$finish;
	end

	// ==============================
	// Test sequence
	// ==============================

	initial begin : main
		logic [31:0] rd;
		logic        err;
		logic [31:0] r;
		logic [7:0]  prev;
		logic [7:0]  answer;
		logic        last_rs;
		logic        active;
		logic [8:0]  x0;
		logic [8:0]  x1;
		logic [8:0]  y0;
		logic [8:0]  y1;
		logic [15:0] color;
		logic [15:0] last_color;
		logic [31:0] wx;
		logic [31:0] wy;
		int          n;
		int          count0;
		int          falls0;
		int          rises0;

		apb_req <= '0;
		rst_n   <= 1'b0;
		repeat (8) @(posedge clock);
		rst_n <= 1'b1;
		@(negedge clock);

		if (lcd_cs_n !== 1'b1) flag_error("chip select not high after reset");
		if (lcd_sck !== 1'b0 || lcd_mosi !== 1'b0) flag_error("SCK or MOSI not low after reset");
		if (lcd_rst_n !== 1'b0) flag_error("LCD reset pin not low after reset");
		apb_access(REG_CTRL, 1'b0, 32'd0, rd, err);
		if (rd !== 32'h1) flag_error($sformatf("CTRL reads %08h after reset", rd));
		apb_access(REG_CTRL, 1'b1, 32'h2, rd, err);  // Select and release LCD reset
		@(negedge clock);
		if (lcd_rst_n !== 1'b1 || lcd_cs_n !== 1'b0) flag_error("CTRL write not on the pins");
		exp_q.push_back({1'b0, 8'h00});  // First link byte goes out with the reset rs
		apb_access(REG_DATA, 1'b0, 32'd0, rd, err);
		if (rd !== 32'h0000_00A5) begin
			flag_error($sformatf("first DATA read %08h, expected a5", rd));
		end
		drain_bytes();
		end_test("reset state and first read");

		prev    = 8'h00;
		last_rs = 1'b0;
		for (int i = 0; i < N_DIRECT; i++) begin
			r       = lcg_next();
			last_rs = r[24];
			prev    = r[23:16];
			exp_q.push_back({last_rs, prev});
			apb_access(last_rs ? REG_DATA : REG_CMD, 1'b1, {24'b0, prev}, rd, err);
			if (err !== 1'b0) flag_error("direct write returned pslverr");
		end
		drain_bytes();
		end_test("direct writes");

		for (int i = 0; i < N_READS; i++) begin
			answer = ~prev;
			exp_q.push_back({last_rs, 8'h00});  // Dummy byte keeps the last rs
			apb_access(REG_DATA, 1'b0, 32'd0, rd, err);
			if (rd !== {24'b0, answer}) begin
				flag_error($sformatf("DATA read %08h, expected %02h", rd, answer));
			end
			prev = 8'h00;
		end
		drain_bytes();
		end_test("direct reads");

		apb_access(REG_CTRL, 1'b1, 32'h3, rd, err);  // Manual deselect between fills
		last_color = 16'h0000;
		for (int k = 0; k < N_FILLS - 1; k++) begin
			pick_span(4, 1'b0, x0, x1);
			pick_span(3, 1'b0, y0, y1);
			r      = lcg_next();
			color  = r[31:16];
			falls0 = cs_falls;
			rises0 = cs_rises;
			start_fill(x0, x1, y0, y1, color, n);
			last_color = color;
			wait_fill_done(active);
			if (!active) flag_error("STATUS fill bit not set during a fill");
			drain_bytes();
			if (cs_falls != falls0 + 1 || cs_rises != rises0 + 1 || lcd_cs_n !== 1'b1) begin
				flag_error("chip select not held low for exactly the fill");
			end
		end
		end_test("rectangle fill");

		pick_span(4, 1'b1, x0, x1);
		pick_span(3, 1'b1, y0, y1);
		r      = lcg_next();
		color  = r[31:16];
		count0 = int'(model_count);
		start_fill(x0, x1, y0, y1, color, n);
		last_color = color;
		apb_access(REG_CMD, 1'b1, 32'h55, rd, err);
		if (err !== 1'b1) flag_error("CMD write during a fill without pslverr");
		apb_access(REG_DATA, 1'b1, 32'hAA, rd, err);
		if (err !== 1'b1) flag_error("DATA write during a fill without pslverr");
		apb_access(REG_FILL_COLOR, 1'b1, {16'b0, ~color}, rd, err);
		if (err !== 1'b1) flag_error("FILL_COLOR write during a fill without pslverr");
		wait_fill_done(active);
		drain_bytes();
		if (int'(model_count) != count0 + n) begin
			flag_error($sformatf("%0d bytes sent, expected %0d", int'(model_count) - count0, n));
		end
		end_test("writes during fill");

		wx = lcg_next();
		wy = lcg_next();
		apb_access(REG_FILL_X, 1'b1, wx, rd, err);
		apb_access(REG_FILL_Y, 1'b1, wy, rd, err);
		apb_access(REG_FILL_X, 1'b0, 32'd0, rd, err);
		if (rd !== (wx & 32'h01FF_01FF)) flag_error($sformatf("FILL_X reads %08h", rd));
		apb_access(REG_FILL_Y, 1'b0, 32'd0, rd, err);
		if (rd !== (wy & 32'h01FF_01FF)) flag_error($sformatf("FILL_Y reads %08h", rd));
		apb_access(REG_FILL_COLOR, 1'b0, 32'd0, rd, err);
		if (rd !== {16'b0, last_color}) flag_error($sformatf("FILL_COLOR reads %08h", rd));
		apb_access(5'h1C, 1'b0, 32'd0, rd, err);
		if (rd !== 32'd0) flag_error($sformatf("unused address reads %08h", rd));
		end_test("register readback");

		$display("Summary: %0d tests passed, %0d tests failed, %0d errors",
			tests_passed, tests_failed, err_cnt + cmp_errs);
		if (tests_failed == 0 && err_cnt + cmp_errs == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/lcd_pkg.sv
logic/lcd_spi_shifter.sv
logic/lcd_fill_engine.sv
logic/lcd_ctrl.sv
logic/lcd_spi_top.sv
dv/lcd_spi_model.sv
dv/tb_lcd_spi.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the LCD SPI testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/tb_lcd_spi

verilator --binary --timing -f vlog.f --top-module tb_lcd_spi -o tb_lcd_spi
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
	echo "Result: pass"
	exit 0
else
	echo "Result: fail, see $LOG"
	exit 1
fi
